// File: music_pkg.sv
package music_pkg;

    // Song entry layout.
    localparam int ENTRY_WIDTH    = 16;
    localparam int NOTE_WIDTH     = 6;
    localparam int DURATION_WIDTH = 6;
    localparam int PARAM_WIDTH    = 3;
    localparam int SONG_SEL_WIDTH = 2;

    // Bit 15 sound, 14..9 note, 8..3 duration, 2..0 voice parameters.
    localparam int SOUND_BIT    = 15;
    localparam int NOTE_LSB     = 9;
    localparam int DURATION_LSB = 3;
    localparam int PARAM_LSB    = 0;

    // ********************
    // Song reader states.
    // ********************
    typedef enum logic [2:0] {
        PAUSED            = 3'b000,
        WAIT              = 3'b001,
        INCREMENT_ADDRESS = 3'b010,
        RETRIEVE_NOTE     = 3'b011,
        NEW_NOTE_READY    = 3'b100
    } reader_state_t;

endpackage

// File: synth_pkg.sv
package synth_pkg;

    localparam int TONE_WIDTH = 16;

    // Tone half-period in clocks is TONE_BASE - note * TONE_STEP.
    // Note 63 still leaves a half-period of 9 clocks.
    localparam logic [TONE_WIDTH-1:0] TONE_BASE = 16'd72;
    localparam logic [TONE_WIDTH-1:0] TONE_STEP = 16'd1;

    // Clock counter inside one beat.
    localparam int BEAT_COUNT_WIDTH = 16;

endpackage

// File: song_rom.sv
`timescale 1ns/100ps

module song_rom #(
    parameter int NOTE_ADDR_WIDTH = 3
) (
    input  logic                                                 clk,
    input  logic [music_pkg::SONG_SEL_WIDTH+NOTE_ADDR_WIDTH-1:0] addr,
    output logic [music_pkg::ENTRY_WIDTH-1:0]                    data
);

    localparam int ADDR_WIDTH = music_pkg::SONG_SEL_WIDTH + NOTE_ADDR_WIDTH;
    localparam int DEPTH      = 1 << ADDR_WIDTH;

    logic [music_pkg::ENTRY_WIDTH-1:0] mem [DEPTH];

    // Four songs, stored back to back.
    initial begin
        $readmemh("song_rom.hex", mem);
    end

    // Registered read, one clock of latency.
    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

// File: song_reader.sv
`timescale 1ns/100ps

module song_reader #(
    parameter int NOTE_ADDR_WIDTH = 3
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 play,
    input  logic [music_pkg::SONG_SEL_WIDTH-1:0]                 song,
    input  logic                                                 note_done,
    input  logic [music_pkg::ENTRY_WIDTH-1:0]                    rom_data,
    output logic [music_pkg::SONG_SEL_WIDTH+NOTE_ADDR_WIDTH-1:0] rom_addr,
    output logic [music_pkg::NOTE_WIDTH-1:0]                     note,
    output logic [music_pkg::DURATION_WIDTH-1:0]                 duration,
    output logic [music_pkg::PARAM_WIDTH-1:0]                    voice_params,
    output logic                                                 sound,
    output logic                                                 new_note,
    output logic                                                 song_done,
    output logic                                                 playing_level
);

    music_pkg::reader_state_t state;
    music_pkg::reader_state_t next_state;

    logic [NOTE_ADDR_WIDTH-1:0] note_index;
    logic [NOTE_ADDR_WIDTH-1:0] next_index;
    logic                       index_carry;

    // ********************
    // State and note index.
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= music_pkg::PAUSED;
            note_index <= '0;
        end else begin
            state      <= next_state;
            note_index <= next_index;
        end
    end

    // Dropping play returns to PAUSED from anywhere.
    always_comb begin
        next_state = music_pkg::PAUSED;
        if (play) begin
            case (state)
                music_pkg::PAUSED:            next_state = music_pkg::RETRIEVE_NOTE;
                music_pkg::RETRIEVE_NOTE:     next_state = music_pkg::NEW_NOTE_READY;
                music_pkg::NEW_NOTE_READY:    next_state = music_pkg::WAIT;
                music_pkg::WAIT: begin
                    next_state = note_done ? music_pkg::INCREMENT_ADDRESS : music_pkg::WAIT;
                end
                music_pkg::INCREMENT_ADDRESS: begin
                    // Song end goes back through PAUSED.
                    next_state = index_carry ? music_pkg::PAUSED : music_pkg::RETRIEVE_NOTE;
                end
                default:                      next_state = music_pkg::PAUSED;
            endcase
        end
    end

    // Carry out of the last index marks the end of the song.
    assign {index_carry, next_index} = (state == music_pkg::INCREMENT_ADDRESS)
                                     ? {1'b0, note_index} + 1'b1
                                     : {1'b0, note_index};

    assign rom_addr      = {song, note_index};
    assign new_note      = (state == music_pkg::NEW_NOTE_READY);
    assign song_done     = index_carry;
    assign playing_level = (state != music_pkg::PAUSED);

    // ********************
    // Entry fields.
    // ********************
    assign note         = rom_data[music_pkg::NOTE_LSB +: music_pkg::NOTE_WIDTH];
    assign duration     = rom_data[music_pkg::DURATION_LSB +: music_pkg::DURATION_WIDTH];
    assign voice_params = rom_data[music_pkg::PARAM_LSB +: music_pkg::PARAM_WIDTH];
    // Flag only counts while playing.
    assign sound        = playing_level & rom_data[music_pkg::SOUND_BIT];

endmodule

// File: note_player.sv
`timescale 1ns/100ps

module note_player #(
    parameter int BEAT_CYCLES = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 new_note,
    input  logic                                 playing_level,
    input  logic                                 sound,
    input  logic [music_pkg::NOTE_WIDTH-1:0]     note,
    input  logic [music_pkg::DURATION_WIDTH-1:0] duration,
    output logic                                 note_done,
    output logic                                 tone
);

    localparam logic [synth_pkg::BEAT_COUNT_WIDTH-1:0] LAST_CYCLE =
        synth_pkg::BEAT_COUNT_WIDTH'(BEAT_CYCLES - 1);

    logic [music_pkg::NOTE_WIDTH-1:0]     note_q;
    logic [music_pkg::DURATION_WIDTH-1:0] dur_q;
    logic                                 sound_q;

    logic                                  active;
    logic [synth_pkg::BEAT_COUNT_WIDTH-1:0] cycle_cnt;
    logic [music_pkg::DURATION_WIDTH-1:0]  beat_cnt;

    logic [synth_pkg::TONE_WIDTH-1:0] half_period;
    logic [synth_pkg::TONE_WIDTH-1:0] tone_cnt;
    logic                             sounding;

    // Latch the new entry.
    always_ff @(posedge clk) begin
        if (new_note) begin
            note_q  <= note;
            dur_q   <= duration;
            sound_q <= sound;
        end
    end

    // ********************
    // Duration in beats.
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            cycle_cnt <= '0;
            beat_cnt  <= '0;
        end else if (!playing_level || new_note) begin
            active    <= new_note & playing_level;
            cycle_cnt <= '0;
            beat_cnt  <= '0;
        end else if (note_done) begin
            active <= 1'b0;
        end else if (active) begin
            if (cycle_cnt == LAST_CYCLE) begin
                cycle_cnt <= '0;
                beat_cnt  <= beat_cnt + 1'b1;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    assign note_done = playing_level & active & (beat_cnt == dur_q);

    // ********************
    // Square-wave tone.
    // ********************
    // Higher notes give shorter half-periods.
    assign half_period = synth_pkg::TONE_BASE
                       - (synth_pkg::TONE_WIDTH'(note_q) * synth_pkg::TONE_STEP);
    assign sounding    = active & sound_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tone     <= 1'b0;
            tone_cnt <= '0;
        end else if (!playing_level || new_note || !sounding) begin
            // Rests and pauses hold the line low.
            tone     <= 1'b0;
            tone_cnt <= '0;
        end else if (tone_cnt == half_period - 1'b1) begin
            tone     <= ~tone;
            tone_cnt <= '0;
        end else begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

endmodule

// File: music_player_top.sv
`timescale 1ns/100ps

module music_player_top #(
    parameter int NOTE_ADDR_WIDTH = 3,
    parameter int BEAT_CYCLES     = 50000
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 play,
    input  logic [music_pkg::SONG_SEL_WIDTH-1:0] song,
    output logic [music_pkg::NOTE_WIDTH-1:0]     note,
    output logic [music_pkg::DURATION_WIDTH-1:0] duration,
    output logic [music_pkg::PARAM_WIDTH-1:0]    voice_params,
    output logic                                 new_note,
    output logic                                 sound,
    output logic                                 tone,
    output logic                                 song_done
);

    logic [music_pkg::SONG_SEL_WIDTH+NOTE_ADDR_WIDTH-1:0] rom_addr;
    logic [music_pkg::ENTRY_WIDTH-1:0]                    rom_data;
    logic                                                 note_done;
    logic                                                 playing_level;

    // Sequencer over the selected song.
    song_reader #(
        .NOTE_ADDR_WIDTH(NOTE_ADDR_WIDTH)
    ) u_song_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .play         (play),
        .song         (song),
        .note_done    (note_done),
        .rom_data     (rom_data),
        .rom_addr     (rom_addr),
        .note         (note),
        .duration     (duration),
        .voice_params (voice_params),
        .sound        (sound),
        .new_note     (new_note),
        .song_done    (song_done),
        .playing_level(playing_level)
    );

    song_rom #(
        .NOTE_ADDR_WIDTH(NOTE_ADDR_WIDTH)
    ) u_song_rom (
        .clk (clk),
        .addr(rom_addr),
        .data(rom_data)
    );

    // Single voice.
    note_player #(
        .BEAT_CYCLES(BEAT_CYCLES)
    ) u_note_player (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_note     (new_note),
        .playing_level(playing_level),
        .sound        (sound),
        .note         (note),
        .duration     (duration),
        .note_done    (note_done),
        .tone         (tone)
    );

endmodule

// File: music_player_sva.sv
`timescale 1ns/100ps

module music_player_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     play,
    input logic                     note_done,
    input logic                     new_note,
    input logic                     song_done,
    input music_pkg::reader_state_t state
);

    // new_note is a single-cycle pulse.
    assert property (@(posedge clk) disable iff (!rst_n)
        new_note |=> !new_note)
        else $error("new_note held high for two cycles");

    // Next note three cycles after note_done while play holds.
    assert property (@(posedge clk) disable iff (!rst_n)
        (note_done && play) ##1 (play && !song_done) ##1 play |=> new_note)
        else $error("new_note missing three cycles after note_done");

    // Song end comes out of the increment step and returns through PAUSED.
    assert property (@(posedge clk) disable iff (!rst_n)
        song_done |-> (state == music_pkg::INCREMENT_ADDRESS) ##1
                      (state == music_pkg::PAUSED))
        else $error("song_done not followed by a return to PAUSED");

endmodule

// File: tb_music_player.sv
`timescale 1ns/100ps

module tb_music_player;

    localparam int BEAT_CYCLES     = 4;
    localparam int NOTE_ADDR_WIDTH = 3;
    localparam int SONG_LEN        = 1 << NOTE_ADDR_WIDTH;
    localparam int ROM_DEPTH       = SONG_LEN << music_pkg::SONG_SEL_WIDTH;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 play;
    logic [music_pkg::SONG_SEL_WIDTH-1:0] song;
    logic [music_pkg::NOTE_WIDTH-1:0]     note;
    logic [music_pkg::DURATION_WIDTH-1:0] duration;
    logic [music_pkg::PARAM_WIDTH-1:0]    voice_params;
    logic                                 new_note;
    logic                                 sound;
    logic                                 tone;
    logic                                 song_done;

    logic [music_pkg::ENTRY_WIDTH-1:0] rom_model [ROM_DEPTH];

    int errors       = 0;
    int tests_failed = 0;
    int cycle_count  = 0;
    int cycle_limit  = 32'h7fff_ffff;

    music_player_top #(
        .NOTE_ADDR_WIDTH(NOTE_ADDR_WIDTH),
        .BEAT_CYCLES    (BEAT_CYCLES)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .play        (play),
        .song        (song),
        .note        (note),
        .duration    (duration),
        .voice_params(voice_params),
        .new_note    (new_note),
        .sound       (sound),
        .tone        (tone),
        .song_done   (song_done)
    );

    bind song_reader music_player_sva u_sva (
        .clk      (clk),
        .rst_n    (rst_n),
        .play     (play),
        .note_done(note_done),
        .new_note (new_note),
        .song_done(song_done),
        .state    (state)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ********************
    // Run limit.
    // ********************
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic compare_note(input string name, input logic [music_pkg::NOTE_WIDTH-1:0] exp,
                                input logic [music_pkg::NOTE_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s note: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_duration(input string name,
                                    input logic [music_pkg::DURATION_WIDTH-1:0] exp,
                                    input logic [music_pkg::DURATION_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s duration: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_params(input string name,
                                  input logic [music_pkg::PARAM_WIDTH-1:0] exp,
                                  input logic [music_pkg::PARAM_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s voice_params: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_interval(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Mismatch %s tone period: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_failure(input string name, input string what);
        $display("Error in %s: %s", name, what);
        errors++;
    endtask

    // Half-period rule from the tone constants.
    function automatic int expected_half_period(input logic [music_pkg::NOTE_WIDTH-1:0] n);
        return int'(synth_pkg::TONE_BASE) - int'(n) * int'(synth_pkg::TONE_STEP);
    endfunction

    task automatic check_idle(input string name);
        compare_bit({name, " new_note"}, 1'b0, new_note);
        compare_bit({name, " song_done"}, 1'b0, song_done);
        compare_bit({name, " sound"}, 1'b0, sound);
        compare_bit({name, " tone"}, 1'b0, tone);
    endtask

    task automatic hold_pause(input string name, input int pause_len);
        @(posedge clk);
        play <= 1'b0;
        repeat (pause_len) begin
            @(negedge clk);
            if (new_note === 1'b1) report_failure(name, "new_note appeared during the pause");
        end
        @(posedge clk);
        play <= 1'b1;
    endtask

    task automatic run_test(input string name, input int song_sel, input int pause_after,
                            input int pause_len);
        logic [music_pkg::ENTRY_WIDTH-1:0] cur;
        int  expect_idx;
        int  done_count;
        int  rises;
        int  last_rise;
        int  errors_before;
        bit  cur_valid;
        bit  paused_once;
        bit  finished;
        bit  tone_prev;
        errors_before = errors;
        expect_idx    = 0;
        done_count    = 0;
        rises         = 0;
        last_rise     = 0;
        cur           = '0;
        cur_valid     = 1'b0;
        paused_once   = 1'b0;
        finished      = 1'b0;
        tone_prev     = 1'b0;
        @(posedge clk);
        song <= music_pkg::SONG_SEL_WIDTH'(song_sel);
        play <= 1'b1;
        while (!finished) begin
            @(negedge clk);
            if (cur_valid && !cur[music_pkg::SOUND_BIT] && tone !== 1'b0)
                report_failure(name, "tone is high during a rest");
            if (cur_valid && tone === 1'b1 && !tone_prev) begin
                if (rises > 0)
                    compare_interval(name, 2 * expected_half_period(
                        cur[music_pkg::NOTE_LSB +: music_pkg::NOTE_WIDTH]),
                        cycle_count - last_rise);
                rises++;
                last_rise = cycle_count;
            end
            tone_prev = (tone === 1'b1);
            if (song_done === 1'b1) begin
                if (expect_idx != SONG_LEN) report_failure(name, "song_done came too early");
                done_count++;
            end
            if (new_note === 1'b1) begin
                if (cur_valid && cur[music_pkg::SOUND_BIT] && rises == 0)
                    report_failure(name, "a sounding note never toggled tone");
                if (expect_idx == SONG_LEN) begin
                    if (done_count != 1)
                        report_failure(name, $sformatf("song_done pulsed %0d times", done_count));
                    expect_idx = 0;
                    finished   = 1'b1;
                end
                cur = rom_model[song_sel * SONG_LEN + expect_idx];
                compare_note(name, cur[music_pkg::NOTE_LSB +: music_pkg::NOTE_WIDTH], note);
                compare_duration(name, cur[music_pkg::DURATION_LSB +: music_pkg::DURATION_WIDTH],
                                 duration);
                compare_params(name, cur[music_pkg::PARAM_LSB +: music_pkg::PARAM_WIDTH],
                               voice_params);
                compare_bit({name, " sound"}, cur[music_pkg::SOUND_BIT], sound);
                cur_valid = 1'b1;
                rises     = 0;
                if (!finished && !paused_once && expect_idx == pause_after - 1) begin
                    // Interrupted entry must come back after the pause.
                    hold_pause(name, pause_len);
                    paused_once = 1'b1;
                    cur_valid   = 1'b0;
                    tone_prev   = 1'b0;
                end else begin
                    expect_idx++;
                end
            end
        end
        @(posedge clk);
        play <= 1'b0;
        if (errors == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: failed", name);
            tests_failed++;
        end
    endtask

    // ********************
    // Main sequence.
    // ********************
    initial begin
        string names [$];
        int    songs [$];
        int    pauses [$];
        int    lengths [$];
        string line;
        string tname;
        int    fd;
        int    n;
        int    s;
        int    pa;
        int    pl;
        int    limit;
        rst_n = 1'b0;
        play  = 1'b0;
        song  = '0;
        $readmemh("song_rom.hex", rom_model);
        fd = $fopen("music_player_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            $display("Simulation FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d", tname, s, pa, pl);
                    if (n == 4) begin
                        names.push_back(tname);
                        songs.push_back(s);
                        pauses.push_back(pa);
                        lengths.push_back(pl);
                    end
                end
            end
            $fclose(fd);
            limit = 50;
            foreach (names[i]) limit += 2 * (8 * (63 * BEAT_CYCLES + 8) + lengths[i]);
            cycle_limit = limit;

            repeat (3) begin
                @(negedge clk);
                check_idle("reset");
            end
            @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            check_idle("after_reset");

            foreach (names[i]) run_test(names[i], songs[i], pauses[i], lengths[i]);

            $display("Tests run %0d, failed %0d, errors %0d", names.size(), tests_failed, errors);
            if (errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

// File: song_rom.hex
// One entry per line: sound(15) note(14:9) duration(8:3) params(2:0), song 0 first
F841
FC52
0010
F463
FE44
F04D
0A08
FA57
F648
F261
0000
F852
FC43
0016
FE54
F445
F045
FA4E
F667
7C10
F850
F241
0008
FE62
FC4B
F454
F843
0018
F65D
F048
FA60
FE41

// File: music_player_patterns.txt
# name song notes_before_pause pause_cycles
# notes_before_pause 0 plays the song through without a pause
song0_full 0 0 0
song1_full 1 0 0
song2_full 2 0 0
song3_full 3 0 0
song0_pause3 0 3 25
song1_pause_rest 1 3 12
song2_pause1 2 1 40
song3_pause8 3 8 7
song1_pause6 1 6 30

// File: filelist.f
music_pkg.sv
synth_pkg.sv
song_rom.sv
song_reader.sv
note_player.sv
music_player_top.sv
music_player_sva.sv
tb_music_player.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_music_player
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
